// ==== sim.f ====
ebusPkg.sv
clkCtlPkg.sv
clockGate.sv
modeRegs.sv
diagReadback.sv
clkBoard.sv
clkBoard_asserts.sv
clkBoardTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = clkBoardTb
FILELIST = sim.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== clkBoardTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module clkBoardTb;

  import ebusPkg::*;
  import clkCtlPkg::*;

  // Longest burst is a count of 255 at one tick every 8 cycles
  localparam int burstWait = 255 * 8 + 16;
  // Reset, mode, free run, three bursts, steps, reset functions, then margin
  localparam int cycleLimit = 30 + 100 + 200 + 3 * (burstWait + 8) + 52 + 16 + 200;

  logic       MBOX_CLK = 1'b0;
  logic       CLK;
  ebusReqT    ebusReq;
  ebusDriveT  ebusDrive;
  sectionClkT sectionClk;
  gateStatusT status;

  integer seed = 68334;
  int     cycleCount = 0;
  int     errorCount = 0;
  int     testCount = 0;
  int     testsFailed = 0;
  int     errorBase = 0;
  int     pulseTally = 0;

  // Reference model state
  gateStatusT mStatus;
  sectionClkT mSecClk;
  modeRegsT   mMode;
  logic [2:0] mPrescale;
  logic       mPending;

  clkBoard dut (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .ebusReq    (ebusReq),
    .ebusDrive  (ebusDrive),
    .sectionClk (sectionClk),
    .status     (status)
  );

  bind clkBoard clkBoardAsserts uAsserts (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .ebusReq     (ebusReq),
    .status      (status),
    .sectionClk  (sectionClk),
    .rateSel     (mode.sourceRate.rateSel),
    .stepPending (uClockGate.stepPending)
  );

  always #10 MBOX_CLK = ~MBOX_CLK;

  always @(posedge MBOX_CLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic checkDrive(input string name, input ebusDriveT got, input ebusDriveT exp);
    if (got !== exp) begin
      errorCount++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkSectionClk(input string name, input sectionClkT got, input sectionClkT exp);
    if (got !== exp) begin
      errorCount++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkStatus(input string name, input gateStatusT got, input gateStatusT exp);
    if (got !== exp) begin
      errorCount++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkPulses(input string name, input int got, input int exp);
    if (got != exp) begin
      errorCount++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic modelReset();
    mStatus = '0;
    mStatus.mrReset = 1'b1;
    mStatus.burstZero = 1'b1;
    mSecClk = '0;
    mMode = '0;
    mPrescale = 3'd0;
    mPending = 1'b0;
  endtask

  // Status word as the bus layout defines it for each select
  function automatic ebusDriveT modelRead(input ebusReqT req);
    ebusDriveT d;
    d = '0;
    if (req.readFunc) begin
      d.driving = 1'b1;
      case (req.sel)
        3'd0: d.word = {mStatus.mrReset, mStatus.running, mStatus.burstActive,
                        mStatus.burstZero, mStatus.burstCount[7:6]};
        3'd1: d.word = mStatus.burstCount[5:0];
        3'd2: d.word = {mMode.sourceRate.rateSel, mMode.sourceRate.sourceSel,
                        mMode.cycleCtl.errStopEn, mMode.cycleCtl.mboxCycleDis};
        3'd3: d.word = {mMode.clkDisable, mMode.cycleCtl.respSim,
                        mMode.cycleCtl.arParCheck, 1'b0};
        3'd4: d.word = {mMode.parityCheck, 2'b00};
        default: d.word = 6'd0;
      endcase
    end
    return d;
  endfunction

  // One rising edge of the board with the given request on the bus
  task automatic modelStep(input ebusReqT req);
    logic [2:0] mask;
    logic       pulse;
    logic       countDown;
    case (mMode.sourceRate.rateSel)
      2'd0: mask = 3'b000;
      2'd1: mask = 3'b001;
      2'd2: mask = 3'b011;
      default: mask = 3'b111;
    endcase
    pulse = ((mPrescale & mask) == 3'b000) &&
            (mStatus.running || mPending || (mStatus.burstActive && !mStatus.burstZero));
    countDown = pulse && mStatus.burstActive && !mStatus.burstZero;
    mSecClk = {3{pulse}} & ~mMode.clkDisable;
    if (pulse) begin
      mPending = 1'b0;
    end
    // Burst ends once the count is used up
    if (mStatus.burstActive &&
        (mStatus.burstZero || (countDown && mStatus.burstCount == 8'd1))) begin
      mStatus.burstActive = 1'b0;
    end
    if (req.ldFunc && req.sel == ldBurstLow) begin
      mStatus.burstCount[3:0] = req.data;
    end else if (req.ldFunc && req.sel == ldBurstHigh) begin
      mStatus.burstCount[7:4] = req.data;
    end else if (countDown) begin
      mStatus.burstCount = mStatus.burstCount - 8'd1;
    end
    if (req.ctlFunc) begin
      case (req.sel)
        ctlStop: begin
          mStatus.running = 1'b0;
          mStatus.burstActive = 1'b0;
          mPending = 1'b0;
        end
        ctlStart:      mStatus.running = 1'b1;
        ctlSingleStep: mPending = 1'b1;
        ctlBurst:      mStatus.burstActive = 1'b1;
        ctlClearReset: mStatus.mrReset = 1'b0;
        ctlSetReset:   mStatus.mrReset = 1'b1;
        default: ;
      endcase
    end
    if (req.ldFunc) begin
      case (req.sel)
        ldSourceRate:   mMode.sourceRate = req.data;
        ldClockDisable: mMode.clkDisable = req.data[2:0];
        ldParityCheck:  mMode.parityCheck = req.data;
        ldCycleControl: mMode.cycleCtl = req.data;
        default: ;
      endcase
    end
    mStatus.burstZero = (mStatus.burstCount == 8'd0);
    mPrescale = mPrescale + 3'd1;
  endtask

  // Registered outputs are checked at the falling edge and the read just after driving
  task automatic applyCycle(input ebusReqT req);
    @(negedge MBOX_CLK);
    checkStatus("status", status, mStatus);
    checkSectionClk("sectionClk", sectionClk, mSecClk);
    if (sectionClk != '0) begin
      pulseTally++;
    end
    ebusReq = req;
    #2;
    checkDrive("ebusDrive", ebusDrive, modelRead(req));
    modelStep(req);
  endtask

  task automatic sendControl(input diagSelT sel);
    applyCycle({3'b100, sel, 4'h0});
  endtask

  task automatic sendLoad(input diagSelT sel, input diagNibbleT data);
    applyCycle({3'b010, sel, data});
  endtask

  task automatic readSelect(input diagSelT sel);
    applyCycle({3'b001, sel, 4'h0});
  endtask

  task automatic idleCycles(input int n);
    repeat (n) applyCycle('0);
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errorCount == errorBase) begin
      $display("Test %0d, %s: passed", testCount, name);
    end else begin
      testsFailed++;
      $display("Test %0d, %s: %0d checks wrong", testCount, name, errorCount - errorBase);
    end
    errorBase = errorCount;
  endtask

  initial begin
    logic [31:0] r;
    int          n;
    int          expPulses;
    ebusReq = '0;
    CLK = 1'b1;
    modelReset();
    repeat (3) @(posedge MBOX_CLK);
    @(negedge MBOX_CLK);
    CLK = 1'b0;
    // First edge out of reset sees an idle bus
    modelStep('0);

    for (int s = 0; s < 8; s++) readSelect(s[2:0]);
    idleCycles(2);
    finishTest("reset state");

    repeat (20) begin
      r = $random(seed);
      sendLoad({1'b1, r[1:0]}, r[7:4]);
      sendLoad({1'b1, r[9:8]}, r[15:12]);
      readSelect(3'd2);
      readSelect(3'd3);
      readSelect(3'd4);
    end
    finishTest("mode registers");

    repeat (4) begin
      r = $random(seed);
      sendLoad(ldSourceRate, r[3:0]);
      sendLoad(ldClockDisable, {1'b0, r[6:4]});
      sendControl(ctlStart);
      idleCycles(10 + int'(r[12:8]));
      sendControl(ctlStop);
      idleCycles(3);
    end
    finishTest("free run");

    sendLoad(ldClockDisable, 4'h0);
    repeat (3) begin
      r = $random(seed);
      sendLoad(ldSourceRate, r[3:0]);
      sendLoad(ldBurstLow, r[11:8]);
      sendLoad(ldBurstHigh, r[15:12]);
      expPulses = int'(r[15:8]);
      pulseTally = 0;
      sendControl(ctlBurst);
      n = 0;
      // Track the count on selects 0 and 1 until the burst is done
      while ((status.burstActive || n == 0) && n < burstWait) begin
        readSelect({2'b00, n[0]});
        n++;
      end
      if (n >= burstWait) begin
        errorCount++;
        $display("Burst of %0d pulses never finished", expPulses);
      end
      idleCycles(2);
      checkPulses("burst pulses", pulseTally, expPulses);
    end
    finishTest("burst");

    repeat (4) begin
      r = $random(seed);
      sendLoad(ldSourceRate, r[3:0]);
      pulseTally = 0;
      sendControl(ctlSingleStep);
      idleCycles(10);
      checkPulses("single step pulses", pulseTally, 1);
    end
    finishTest("single step");

    repeat (8) begin
      r = $random(seed);
      sendControl(r[0] ? ctlSetReset : ctlClearReset);
      readSelect(3'd0);
    end
    idleCycles(1);
    finishTest("reset functions");

    $display("Tests run %0d, tests failed %0d, checks failed %0d, assertions failed %0d",
             testCount, testsFailed, errorCount, dut.uAsserts.assertFails);
    if (errorCount == 0 && dut.uAsserts.assertFails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== clkBoard_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module clkBoardAsserts (
  input logic                  MBOX_CLK,
  input logic                  CLK,
  input ebusPkg::ebusReqT      ebusReq,
  input clkCtlPkg::gateStatusT status,
  input clkCtlPkg::sectionClkT sectionClk,
  input logic [1:0]            rateSel,
  input logic                  stepPending
);

  import ebusPkg::*;

  // Failed assertions, summed up by the testbench
  int assertFails = 0;

  // Master reset comes out of reset set
  assert property (@(posedge MBOX_CLK) $fell(CLK) |-> status.mrReset)
    else begin
      assertFails++;
      $error("mrReset low in the first cycle after reset");
    end

  // Above rate 0 a tick is never followed by another tick
  assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (sectionClk != '0 && rateSel != 2'd0 && $past(rateSel) != 2'd0) |=> (sectionClk == '0))
    else begin
      assertFails++;
      $error("Section pulse lasted two cycles at a divided rate");
    end

  // Every pulse needs run, burst or step behind it
  assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (sectionClk != '0) |-> $past(status.running | status.burstActive | stepPending))
    else begin
      assertFails++;
      $error("Section pulse with no run, burst or step source");
    end

  // Count goes up only through a nibble load
  assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (status.burstCount > $past(status.burstCount)) |->
      $past(ebusReq.ldFunc && (ebusReq.sel == ldBurstLow || ebusReq.sel == ldBurstHigh)))
    else begin
      assertFails++;
      $error("Burst count rose without a burst count load");
    end

endmodule

`default_nettype wire

// ==== clkBoard.sv ====
`timescale 1ns/100ps
`default_nettype none

module clkBoard (
  input  logic                  MBOX_CLK,
  input  logic                  CLK,
  input  ebusPkg::ebusReqT      ebusReq,
  output ebusPkg::ebusDriveT    ebusDrive,
  output clkCtlPkg::sectionClkT sectionClk,
  output clkCtlPkg::gateStatusT status
);

  import clkCtlPkg::*;

  // Board configuration shared by the pulse generator and readback
  modeRegsT mode;

  clockGate uClockGate (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .ebusReq    (ebusReq),
    .rateSel    (mode.sourceRate.rateSel),
    .clkDisable (mode.clkDisable),
    .status     (status),
    .sectionClk (sectionClk)
  );

  modeRegs uModeRegs (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .ebusReq  (ebusReq),
    .mode     (mode)
  );

  diagReadback uDiagReadback (
    .ebusReq   (ebusReq),
    .status    (status),
    .mode      (mode),
    .ebusDrive (ebusDrive)
  );

endmodule

`default_nettype wire

// ==== diagReadback.sv ====
`timescale 1ns/100ps
`default_nettype none

module diagReadback (
  input  ebusPkg::ebusReqT      ebusReq,
  input  clkCtlPkg::gateStatusT status,
  input  clkCtlPkg::modeRegsT   mode,
  output ebusPkg::ebusDriveT    ebusDrive
);

  // Status word for each read select, MSB is bus bit 30
  always_comb begin
    ebusDrive = '0;
    if (ebusReq.readFunc) begin
      ebusDrive.driving = 1'b1;
      case (ebusReq.sel)
        3'd0: begin
          ebusDrive.word = {status.mrReset,
                            status.running,
                            status.burstActive,
                            status.burstZero,
                            status.burstCount[7:6]};
        end
        3'd1: begin
          ebusDrive.word = status.burstCount[5:0];
        end
        3'd2: begin
          ebusDrive.word = {mode.sourceRate.rateSel,
                            mode.sourceRate.sourceSel,
                            mode.cycleCtl.errStopEn,
                            mode.cycleCtl.mboxCycleDis};
        end
        3'd3: begin
          ebusDrive.word = {mode.clkDisable.crmDis,
                            mode.clkDisable.edpDis,
                            mode.clkDisable.ctlDis,
                            mode.cycleCtl.respSim,
                            mode.cycleCtl.arParCheck,
                            1'b0};
        end
        3'd4: begin
          ebusDrive.word = {mode.parityCheck.fmCheck,
                            mode.parityCheck.cramCheck,
                            mode.parityCheck.dramCheck,
                            mode.parityCheck.fsCheck,
                            2'b00};
        end
        // Selects 5 to 7 read as zero
        default: begin
          ebusDrive.word = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== modeRegs.sv ====
`timescale 1ns/100ps
`default_nettype none

module modeRegs (
  input  logic                MBOX_CLK,
  input  logic                CLK,
  input  ebusPkg::ebusReqT    ebusReq,
  output clkCtlPkg::modeRegsT mode
);

  import ebusPkg::*;

  logic loadStrobe;
  logic upperCode;

  // Codes 4 to 7 all have the top select bit set
  assign upperCode  = ebusReq.sel[2];
  assign loadStrobe = ebusReq.ldFunc & upperCode;

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mode <= '0;
    end else if (loadStrobe) begin
      case (ldFuncE'(ebusReq.sel))
        ldSourceRate: begin
          mode.sourceRate <= ebusReq.data;
        end
        // Bus bits 33 to 35, bit 32 unused
        ldClockDisable: begin
          mode.clkDisable <= ebusReq.data[2:0];
        end
        ldParityCheck: begin
          mode.parityCheck <= ebusReq.data;
        end
        ldCycleControl: begin
          mode.cycleCtl <= ebusReq.data;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== clockGate.sv ====
`timescale 1ns/100ps
`default_nettype none

module clockGate (
  input  logic                  MBOX_CLK,
  input  logic                  CLK,
  input  ebusPkg::ebusReqT      ebusReq,
  input  logic [1:0]            rateSel,
  input  clkCtlPkg::clkDisableT clkDisable,
  output clkCtlPkg::gateStatusT status,
  output clkCtlPkg::sectionClkT sectionClk
);

  import ebusPkg::*;
  import clkCtlPkg::*;

  logic       running;
  logic       burstActive;
  logic       stepPending;
  logic       mrReset;
  logic [2:0] prescale;
  burstCountT burstCount;

  logic burstZero;
  logic tick;
  logic pulseEn;
  logic fire;
  logic burstDec;
  logic burstLoad;

  // Tick when the low rateSel bits of the prescaler are all zero
  always_comb begin
    case (rateSel)
      2'd0:    tick = 1'b1;
      2'd1:    tick = (prescale[0] == 1'b0);
      2'd2:    tick = (prescale[1:0] == 2'b00);
      default: tick = (prescale == 3'b000);
    endcase
  end

  assign burstZero = (burstCount == '0);
  assign pulseEn   = running | (burstActive & ~burstZero) | stepPending;
  assign fire      = tick & pulseEn;
  assign burstDec  = fire & burstActive & ~burstZero;
  assign burstLoad = ebusReq.ldFunc &
                     ((ebusReq.sel == ldBurstLow) | (ebusReq.sel == ldBurstHigh));

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      prescale   <= '0;
      sectionClk <= '0;
    end else begin
      prescale       <= prescale + 3'd1;
      // Each section pulse lasts one cycle
      sectionClk.crm <= fire & ~clkDisable.crmDis;
      sectionClk.edp <= fire & ~clkDisable.edpDis;
      sectionClk.ctl <= fire & ~clkDisable.ctlDis;
    end
  end

  // Burst counter, nibble loads take priority over counting
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
    end else if (burstLoad) begin
      if (ebusReq.sel == ldBurstLow) begin
        burstCount[3:0] <= ebusReq.data;
      end else begin
        burstCount[7:4] <= ebusReq.data;
      end
    end else if (burstDec) begin
      burstCount <= burstCount - 8'd1;
    end
  end

  // Run, burst, single step and master reset flip-flops
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      running     <= 1'b0;
      burstActive <= 1'b0;
      stepPending <= 1'b0;
      mrReset     <= 1'b1;
    end else begin
      if (fire) begin
        stepPending <= 1'b0;
      end
      // Last burst pulse, or a burst started with nothing to count
      if ((burstDec && burstCount == 8'd1) || (burstActive && burstZero)) begin
        burstActive <= 1'b0;
      end
      if (ebusReq.ctlFunc) begin
        case (ctlFuncE'(ebusReq.sel))
          ctlStop: begin
            running     <= 1'b0;
            burstActive <= 1'b0;
            stepPending <= 1'b0;
          end
          ctlStart:      running     <= 1'b1;
          ctlSingleStep: stepPending <= 1'b1;
          ctlBurst:      burstActive <= 1'b1;
          ctlClearReset: mrReset     <= 1'b0;
          ctlSetReset:   mrReset     <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    status.mrReset     = mrReset;
    status.running     = running;
    status.burstActive = burstActive;
    status.burstZero   = burstZero;
    status.burstCount  = burstCount;
  end

endmodule

`default_nettype wire

// ==== clkCtlPkg.sv ====
`default_nettype none

// Clock board configuration and status formats
package clkCtlPkg;

  typedef logic [7:0] burstCountT;

  // Load code 4
  typedef struct packed {
    logic [1:0] sourceSel;
    logic [1:0] rateSel;
  } sourceRateT;

  // Load code 5, per section clock disables
  typedef struct packed {
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } clkDisableT;

  // Load code 6, stored for readback only
  typedef struct packed {
    logic fmCheck;
    logic cramCheck;
    logic dramCheck;
    logic fsCheck;
  } parityCheckT;

  // Load code 7
  typedef struct packed {
    logic mboxCycleDis;
    logic respSim;
    logic arParCheck;
    logic errStopEn;
  } cycleCtlT;

  typedef struct packed {
    sourceRateT  sourceRate;
    clkDisableT  clkDisable;
    parityCheckT parityCheck;
    cycleCtlT    cycleCtl;
  } modeRegsT;

  typedef struct packed {
    logic       mrReset;
    logic       running;
    logic       burstActive;
    logic       burstZero;
    burstCountT burstCount;
  } gateStatusT;

  // One pulse per processor section
  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } sectionClkT;

endpackage

`default_nettype wire

// ==== ebusPkg.sv ====
`default_nettype none

// Diagnostic bus function codes and transfer formats
package ebusPkg;

  // Diagnostic select field, bus DS 4 to 6
  typedef logic [2:0] diagSelT;

  // Data nibble, bus bits 32 to 35 with bit 32 as the MSB
  typedef logic [3:0] diagNibbleT;

  // Control function codes, 3 and 4 do nothing on this board
  typedef enum diagSelT {
    ctlStop       = 3'd0,
    ctlStart      = 3'd1,
    ctlSingleStep = 3'd2,
    ctlBurst      = 3'd5,
    ctlClearReset = 3'd6,
    ctlSetReset   = 3'd7
  } ctlFuncE;

  // Load function codes, 0 and 1 are ignored
  typedef enum diagSelT {
    ldBurstLow     = 3'd2,
    ldBurstHigh    = 3'd3,
    ldSourceRate   = 3'd4,
    ldClockDisable = 3'd5,
    ldParityCheck  = 3'd6,
    ldCycleControl = 3'd7
  } ldFuncE;

  typedef struct packed {
    logic       ctlFunc;
    logic       ldFunc;
    logic       readFunc;
    diagSelT    sel;
    diagNibbleT data;
  } ebusReqT;

  // Word holds bus bits 30 to 35, bit 30 in the MSB
  typedef struct packed {
    logic       driving;
    logic [5:0] word;
  } ebusDriveT;

endpackage

`default_nettype wire
